// File: design/vadd_pkg.sv
/*
 * Shared widths and types for the vector add/compare lane.
 * The datapath is fixed at one 64-bit word of eight byte slices.
 */
package vadd_pkg;

    localparam int NUM_BYTES  = 8;
    localparam int BYTE_WIDTH = 8;
    localparam int DATA_WIDTH = NUM_BYTES * BYTE_WIDTH;
    localparam int NUM_OSIZES = 4;

    typedef logic [DATA_WIDTH-1:0] vdata_t;
    typedef logic [NUM_BYTES-1:0][BYTE_WIDTH-1:0] byte_vec_t;

    // One bit per byte slice
    typedef logic [NUM_BYTES-1:0] flag_vec_t;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_MINU   = 4'd2,
        OP_MIN    = 4'd3,
        OP_MAXU   = 4'd4,
        OP_MAX    = 4'd5,
        OP_SEQ    = 4'd6,
        OP_SNE    = 4'd7,
        OP_SLT    = 4'd8,
        OP_SLTU   = 4'd9,
        OP_SGT    = 4'd10,
        OP_SGTU   = 4'd11,
        OP_REDSUM = 4'd12,
        OP_REDMAX = 4'd13
    } vadd_op_e;

    // Encoding is log2 of the element byte count
    typedef enum logic [1:0] {
        OS_8  = 2'd0,
        OS_16 = 2'd1,
        OS_32 = 2'd2,
        OS_64 = 2'd3
    } osize_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        FOLD   = 2'd1,
        FINISH = 2'd2
    } ctrl_state_e;

endpackage

// File: design/vadd_ctrl.sv
/*
 * Op decode and reduction sequencing. Start is taken only in IDLE.
 * Reductions spend one FOLD pass per halving of the element count.
 */
module vadd_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  vadd_pkg::vadd_op_e op,
    input  vadd_pkg::osize_e   osize,
    output logic               busy,
    output logic               done,
    output logic               is_sub,
    output logic               is_signed,
    output logic               is_min_max,
    output logic               is_max,
    output logic               is_arith,
    output logic               is_reduct,
    output logic               fold,
    output logic               acc_load,
    output logic               final_mask,
    output vadd_pkg::vadd_op_e cmp_sel,
    output logic [1:0]         fold_span,
    output vadd_pkg::osize_e   osize_q
);
    import vadd_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_n;
    vadd_op_e    op_lat;
    osize_e      osize_lat;
    vadd_op_e    op_cur;
    logic [1:0]  span_cnt;
    logic        accept;

    assign accept  = start && (state == IDLE);
    assign op_cur  = (state == IDLE) ? op : op_lat;
    assign osize_q = (state == IDLE) ? osize : osize_lat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_lat    <= OP_ADD;
            osize_lat <= OS_8;
        end else if (accept) begin
            op_lat    <= op;
            osize_lat <= osize;
        end
    end

    always_comb begin
        is_sub     = !(op_cur inside {OP_ADD, OP_REDSUM});
        is_signed  = op_cur inside {OP_ADD, OP_SUB, OP_MIN, OP_MAX, OP_SLT, OP_SGT,
                                    OP_REDSUM, OP_REDMAX};
        is_min_max = op_cur inside {OP_MIN, OP_MINU, OP_MAX, OP_MAXU, OP_REDMAX};
        is_max     = op_cur inside {OP_MAX, OP_MAXU, OP_REDMAX};
        is_arith   = op_cur inside {OP_ADD, OP_SUB, OP_REDSUM};
        is_reduct  = op_cur inside {OP_REDSUM, OP_REDMAX};
        cmp_sel    = op_cur;
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_n = (is_reduct && osize != OS_64) ? FOLD : FINISH;
                end
            end
            FOLD: begin
                if (span_cnt == 2'd0) begin
                    state_n = FINISH;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            span_cnt <= 2'd0;
        end else begin
            state <= state_n;
            // First fold merges half of all elements
            if (accept) begin
                span_cnt <= 2'd2 - 2'(osize);
            end else if (fold && span_cnt != 2'd0) begin
                span_cnt <= span_cnt - 2'd1;
            end
        end
    end

    assign busy       = (state != IDLE);
    assign done       = (state == FINISH);
    assign fold       = (state == FOLD);
    assign fold_span  = span_cnt;
    assign acc_load   = accept || fold;
    // A single 64-bit element needs no fold, so the seed pass is the last one
    assign final_mask = (fold && span_cnt == 2'd0) ||
                        (accept && is_reduct && osize == OS_64);

endmodule

// File: design/vadd_seg_adder.sv
/*
 * Eight ripple byte adders with the carry cut at element boundaries.
 * The less bit is only meaningful for subtraction, at an element's top byte.
 */
module vadd_seg_adder (
    input  vadd_pkg::vdata_t    a_in,
    input  vadd_pkg::vdata_t    b_in,
    input  vadd_pkg::flag_vec_t b_valid,
    input  vadd_pkg::osize_e    osize,
    input  logic                is_sub,
    input  logic                is_signed,
    output vadd_pkg::vdata_t    sum,
    output vadd_pkg::flag_vec_t cout,
    output vadd_pkg::flag_vec_t prev_cout,
    output vadd_pkg::flag_vec_t zf_byte,
    output vadd_pkg::flag_vec_t less
);
    import vadd_pkg::*;

    byte_vec_t a_b;
    byte_vec_t b_b;
    byte_vec_t s_b;

    assign a_b = a_in;
    assign b_b = b_in;
    assign sum = s_b;

    always_comb begin
        int                    eb;
        logic [BYTE_WIDTH:0]   ext;
        logic [BYTE_WIDTH-1:0] b_op;
        logic                  cin;
        logic                  chain;

        eb    = 1 << osize;
        chain = 1'b0;
        for (int i = 0; i < NUM_BYTES; i++) begin
            b_op = b_valid[i] ? (b_b[i] ^ {BYTE_WIDTH{is_sub}}) : '0;
            // Base byte takes the subtract carry, others chain
            if ((i & (eb - 1)) == 0) begin
                cin = is_sub & b_valid[i];
            end else begin
                cin = chain;
            end
            ext          = {1'b0, a_b[i]} + {1'b0, b_op} + {{BYTE_WIDTH{1'b0}}, cin};
            s_b[i]       = ext[BYTE_WIDTH-1:0];
            cout[i]      = ext[BYTE_WIDTH];
            prev_cout[i] = a_b[i][BYTE_WIDTH-1] ^ b_op[BYTE_WIDTH-1] ^ ext[BYTE_WIDTH-1];
            zf_byte[i]   = (ext[BYTE_WIDTH-1:0] == '0);
            if (is_signed) begin
                less[i] = ext[BYTE_WIDTH-1] ^ (cout[i] ^ prev_cout[i]);
            end else begin
                less[i] = ~cout[i];
            end
            chain = cout[i];
        end
    end

endmodule

// File: design/vadd_select.sv
/*
 * Min/max pick, compare mask and result merge. Compare masks land in the
 * low bits with one bit per element. Flags sit at element top bytes only.
 */
module vadd_select (
    input  vadd_pkg::vdata_t    a_in,
    input  vadd_pkg::vdata_t    b_in,
    input  vadd_pkg::vdata_t    sum,
    input  vadd_pkg::flag_vec_t cout,
    input  vadd_pkg::flag_vec_t prev_cout,
    input  vadd_pkg::flag_vec_t zf_byte,
    input  vadd_pkg::flag_vec_t less,
    input  vadd_pkg::flag_vec_t b_valid,
    input  vadd_pkg::osize_e    osize,
    input  vadd_pkg::vadd_op_e  cmp_sel,
    input  logic                is_arith,
    input  logic                is_min_max,
    input  logic                is_max,
    input  logic                is_signed,
    input  logic                is_sub,
    input  logic                final_mask,
    output vadd_pkg::vdata_t    next_result,
    output vadd_pkg::flag_vec_t zf,
    output vadd_pkg::flag_vec_t cf,
    output vadd_pkg::flag_vec_t of
);
    import vadd_pkg::*;

    byte_vec_t a_b;
    byte_vec_t b_b;
    byte_vec_t mm_b;
    byte_vec_t merged;
    flag_vec_t elem_zf;
    flag_vec_t top_byte;
    flag_vec_t elem0;
    flag_vec_t cmp_mask;
    flag_vec_t keep;
    logic      is_cmp;

    assign a_b    = a_in;
    assign b_b    = b_in;
    assign is_cmp = cmp_sel inside {OP_SEQ, OP_SNE, OP_SLT, OP_SLTU, OP_SGT, OP_SGTU};

    always_comb begin
        int   eb;
        int   base;
        int   top;
        logic all_zero;

        eb = 1 << osize;
        for (int i = 0; i < NUM_BYTES; i++) begin
            base     = i & ~(eb - 1);
            top      = base + eb - 1;
            all_zero = 1'b1;
            for (int j = 0; j < NUM_BYTES; j++) begin
                if ((j & ~(eb - 1)) == base) begin
                    all_zero = all_zero & zf_byte[j];
                end
            end
            elem_zf[i]  = all_zero;
            top_byte[i] = (i == top);
            elem0[i]    = (i < eb);
            // Invalid elements keep a
            if ((is_max ^ less[top]) || !b_valid[base]) begin
                mm_b[i] = a_b[i];
            end else begin
                mm_b[i] = b_b[i];
            end
        end
    end

    always_comb begin
        int   eb;
        int   t;
        logic eq;
        logic lt;

        eb       = 1 << osize;
        cmp_mask = '0;
        for (int e = 0; e < NUM_BYTES; e++) begin
            t  = e * eb + eb - 1;
            eq = 1'b0;
            lt = 1'b0;
            if (t < NUM_BYTES) begin
                eq = elem_zf[t];
                lt = less[t];
                case (cmp_sel)
                    OP_SEQ:          cmp_mask[e] = eq;
                    OP_SNE:          cmp_mask[e] = ~eq;
                    OP_SLT, OP_SLTU: cmp_mask[e] = lt;
                    default:         cmp_mask[e] = ~(eq | lt);
                endcase
            end
        end
    end

    always_comb begin
        if (is_arith) begin
            merged = sum;
        end else if (is_min_max) begin
            merged = mm_b;
        end else begin
            merged = vdata_t'(cmp_mask);
        end
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (final_mask && !elem0[i]) begin
                merged[i] = '0;
            end
        end
    end

    assign next_result = merged;

    assign keep = top_byte & {NUM_BYTES{~is_cmp}} & (final_mask ? elem0 : '1);
    assign zf   = elem_zf & keep;
    // Borrow for subtraction is the inverted carry
    assign cf   = (cout ^ {NUM_BYTES{is_sub}}) & keep;
    assign of   = (is_signed ? (cout ^ prev_cout) : (cout ^ {NUM_BYTES{is_sub}})) & keep;

endmodule

// File: design/vadd_reduct_src.sv
/*
 * Adder operand source. Fold passes add the upper half of the active
 * span of acc onto its lower half.
 */
module vadd_reduct_src (
    input  vadd_pkg::vdata_t    srca,
    input  vadd_pkg::vdata_t    srcb,
    input  vadd_pkg::vdata_t    acc,
    input  vadd_pkg::osize_e    osize,
    input  logic                is_reduct,
    input  logic                fold,
    input  logic [1:0]          fold_span,
    output vadd_pkg::vdata_t    a_in,
    output vadd_pkg::vdata_t    b_in,
    output vadd_pkg::flag_vec_t b_valid
);
    import vadd_pkg::*;

    logic [2:0] half_log2;
    logic [3:0] half_bytes;
    logic [3:0] elem_bytes;

    // Bytes in half of the active span
    assign half_log2  = {1'b0, osize} + {1'b0, fold_span};
    assign half_bytes = 4'd1 << half_log2;
    assign elem_bytes = 4'd1 << osize;

    always_comb begin
        if (fold) begin
            a_in = acc;
            b_in = acc >> {half_bytes, 3'b000};
        end else begin
            a_in = srca;
            b_in = srcb;
        end
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (fold) begin
                b_valid[i] = (4'(i) < half_bytes);
            end else if (is_reduct) begin
                // Seed with srcb element 0 only
                b_valid[i] = (4'(i) < elem_bytes);
            end else begin
                b_valid[i] = 1'b1;
            end
        end
    end

endmodule

// File: design/vadd_result_reg.sv
/*
 * Result and flag registers. Result doubles as the reduction accumulator.
 */
module vadd_result_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                acc_load,
    input  vadd_pkg::vdata_t    next_result,
    input  vadd_pkg::flag_vec_t zf_n,
    input  vadd_pkg::flag_vec_t cf_n,
    input  vadd_pkg::flag_vec_t of_n,
    output vadd_pkg::vdata_t    result,
    output vadd_pkg::flag_vec_t zf,
    output vadd_pkg::flag_vec_t cf,
    output vadd_pkg::flag_vec_t of
);
    import vadd_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            zf     <= '0;
            cf     <= '0;
            of     <= '0;
        end else if (acc_load) begin
            result <= next_result;
            zf     <= zf_n;
            cf     <= cf_n;
            of     <= of_n;
        end
    end

endmodule

// File: design/vadd_unit.sv
/*
 * Vector add/compare lane top. start and done are one-cycle pulses.
 * Inputs are sampled only with start while not busy.
 */
module vadd_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  vadd_pkg::vadd_op_e  op,
    input  vadd_pkg::osize_e    osize,
    input  vadd_pkg::vdata_t    srca,
    input  vadd_pkg::vdata_t    srcb,
    output vadd_pkg::vdata_t    result,
    output vadd_pkg::flag_vec_t zf,
    output vadd_pkg::flag_vec_t cf,
    output vadd_pkg::flag_vec_t of,
    output logic                busy,
    output logic                done
);
    import vadd_pkg::*;

    logic       is_sub;
    logic       is_signed;
    logic       is_min_max;
    logic       is_max;
    logic       is_arith;
    logic       is_reduct;
    logic       fold;
    logic       acc_load;
    logic       final_mask;
    vadd_op_e   cmp_sel;
    logic [1:0] fold_span;
    osize_e     osize_q;
    vdata_t     a_in;
    vdata_t     b_in;
    vdata_t     sum;
    vdata_t     next_result;
    flag_vec_t  b_valid;
    flag_vec_t  cout;
    flag_vec_t  prev_cout;
    flag_vec_t  zf_byte;
    flag_vec_t  less;
    flag_vec_t  zf_n;
    flag_vec_t  cf_n;
    flag_vec_t  of_n;

    vadd_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op         (op),
        .osize      (osize),
        .busy       (busy),
        .done       (done),
        .is_sub     (is_sub),
        .is_signed  (is_signed),
        .is_min_max (is_min_max),
        .is_max     (is_max),
        .is_arith   (is_arith),
        .is_reduct  (is_reduct),
        .fold       (fold),
        .acc_load   (acc_load),
        .final_mask (final_mask),
        .cmp_sel    (cmp_sel),
        .fold_span  (fold_span),
        .osize_q    (osize_q)
    );

    // Accumulator is the registered result
    vadd_reduct_src u_src (
        .srca      (srca),
        .srcb      (srcb),
        .acc       (result),
        .osize     (osize_q),
        .is_reduct (is_reduct),
        .fold      (fold),
        .fold_span (fold_span),
        .a_in      (a_in),
        .b_in      (b_in),
        .b_valid   (b_valid)
    );

    vadd_seg_adder u_adder (
        .a_in      (a_in),
        .b_in      (b_in),
        .b_valid   (b_valid),
        .osize     (osize_q),
        .is_sub    (is_sub),
        .is_signed (is_signed),
        .sum       (sum),
        .cout      (cout),
        .prev_cout (prev_cout),
        .zf_byte   (zf_byte),
        .less      (less)
    );

    vadd_select u_select (
        .a_in        (a_in),
        .b_in        (b_in),
        .sum         (sum),
        .cout        (cout),
        .prev_cout   (prev_cout),
        .zf_byte     (zf_byte),
        .less        (less),
        .b_valid     (b_valid),
        .osize       (osize_q),
        .cmp_sel     (cmp_sel),
        .is_arith    (is_arith),
        .is_min_max  (is_min_max),
        .is_max      (is_max),
        .is_signed   (is_signed),
        .is_sub      (is_sub),
        .final_mask  (final_mask),
        .next_result (next_result),
        .zf          (zf_n),
        .cf          (cf_n),
        .of          (of_n)
    );

    vadd_result_reg u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_load    (acc_load),
        .next_result (next_result),
        .zf_n        (zf_n),
        .cf_n        (cf_n),
        .of_n        (of_n),
        .result      (result),
        .zf          (zf),
        .cf          (cf),
        .of          (of)
    );

endmodule

// File: sim/vadd_checker.sv
/*
 * Bound into vadd_unit. Checks outputs against the testbench expectation
 * at done, plus reset values and done latency. err_cnt counts failures.
 */
module vadd_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                start,
    input logic                busy,
    input logic                done,
    input vadd_pkg::vdata_t    result,
    input vadd_pkg::flag_vec_t zf,
    input vadd_pkg::flag_vec_t cf,
    input vadd_pkg::flag_vec_t of,
    input vadd_pkg::vdata_t    exp_result,
    input vadd_pkg::flag_vec_t exp_zf,
    input vadd_pkg::flag_vec_t exp_cf,
    input vadd_pkg::flag_vec_t exp_of,
    input logic [2:0]          exp_lat
);
    timeunit 1ns;
    timeprecision 1ps;
    import vadd_pkg::*;

    int         err_cnt;
    logic [2:0] lat_cnt;

    initial err_cnt = 0;

    // Cycles since the accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= 3'd0;
        end else if (start && !busy) begin
            lat_cnt <= 3'd1;
        end else if (busy) begin
            lat_cnt <= lat_cnt + 3'd1;
        end
    end

    a_reset_vals: assert property (@(posedge clk)
        !rst_n |-> (!busy && !done && result == '0 && zf == '0 && cf == '0 && of == '0))
    else begin
        err_cnt++;
        $error("outputs not cleared while reset is asserted");
    end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> result == exp_result)
    else begin
        err_cnt++;
        $error("ERR result exp %h got %h", $sampled(exp_result), $sampled(result));
    end

    a_zf: assert property (@(posedge clk) disable iff (!rst_n) done |-> zf == exp_zf)
    else begin
        err_cnt++;
        $error("ERR zf exp %h got %h", $sampled(exp_zf), $sampled(zf));
    end

    a_cf: assert property (@(posedge clk) disable iff (!rst_n) done |-> cf == exp_cf)
    else begin
        err_cnt++;
        $error("ERR cf exp %h got %h", $sampled(exp_cf), $sampled(cf));
    end

    a_of: assert property (@(posedge clk) disable iff (!rst_n) done |-> of == exp_of)
    else begin
        err_cnt++;
        $error("ERR of exp %h got %h", $sampled(exp_of), $sampled(of));
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (lat_cnt == exp_lat && busy))
    else begin
        err_cnt++;
        $error("done came %0d cycles after start, expected %0d",
               $sampled(lat_cnt), $sampled(exp_lat));
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
        err_cnt++;
        $error("done stayed high for more than one cycle");
    end

endmodule

// File: sim/vadd_tb.sv
/*
 * Testbench for vadd_unit. Random operands from a 32-bit Galois LFSR.
 * Expected values come from a per-element model; vadd_checker compares.
 */
module vadd_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vadd_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      start;
    vadd_op_e  op;
    osize_e    osize;
    vdata_t    srca;
    vdata_t    srcb;
    vdata_t    result;
    flag_vec_t zf;
    flag_vec_t cf;
    flag_vec_t of;
    logic      busy;
    logic      done;

    vdata_t     exp_result;
    flag_vec_t  exp_zf;
    flag_vec_t  exp_cf;
    flag_vec_t  exp_of;
    logic [2:0] exp_lat;
    logic [31:0] lfsr;
    int         test_cnt;
    int         fail_cnt;

    vadd_unit dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .osize  (osize),
        .srca   (srca),
        .srcb   (srcb),
        .result (result),
        .zf     (zf),
        .cf     (cf),
        .of     (of),
        .busy   (busy),
        .done   (done)
    );

    bind vadd_unit vadd_checker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .zf         (zf),
        .cf         (cf),
        .of         (of),
        .exp_result (vadd_tb.exp_result),
        .exp_zf     (vadd_tb.exp_zf),
        .exp_cf     (vadd_tb.exp_cf),
        .exp_of     (vadd_tb.exp_of),
        .exp_lat    (vadd_tb.exp_lat)
    );

    always #5 clk = ~clk;

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] elem_mask(input int eb);
        return (eb == 8) ? '1 : ((64'd1 << (eb * 8)) - 64'd1);
    endfunction

    // Elements picked by a random bit copy a, the rest are random
    function automatic vdata_t mix_equal(input vdata_t a, input osize_e s);
        vdata_t r;
        vdata_t m;
        int     eb;
        eb = 1 << s;
        r  = rand_bits(64);
        m  = '0;
        for (int e = 0; e < 8 / eb; e++) begin
            if (rand_bits(1) != 0) begin
                m = m | (elem_mask(eb) << (e * eb * 8));
            end
        end
        return (a & m) | (r & ~m);
    endfunction

    // Picked elements give a zero sum (add) or zero difference (sub)
    function automatic vdata_t zero_partner(input vdata_t a, input osize_e s, input logic neg);
        vdata_t b;
        vdata_t r;
        vdata_t x;
        int     eb;
        eb = 1 << s;
        b  = '0;
        for (int e = 0; e < 8 / eb; e++) begin
            x = (a >> (e * eb * 8)) & elem_mask(eb);
            r = rand_bits(64) & elem_mask(eb);
            if (rand_bits(1) != 0) begin
                r = neg ? ((-x) & elem_mask(eb)) : x;
            end
            b = b | (r << (e * eb * 8));
        end
        return b;
    endfunction

    // One element pair; flags of the add or of the compare subtraction x - y
    task automatic pair_eval(input vadd_op_e o, input logic [63:0] x, input logic [63:0] y,
                             input int eb, output logic [63:0] r, output logic z,
                             output logic c, output logic ov);
        logic [64:0] ext;
        logic [63:0] m;
        logic [63:0] sb;
        logic        sx;
        logic        sy;
        logic        sr;
        logic        eq;
        logic        lt;
        logic        sgn;
        m  = elem_mask(eb);
        sb = 64'd1 << (eb * 8 - 1);
        sx = |(x & sb);
        sy = |(y & sb);
        if (o == OP_ADD || o == OP_REDSUM) begin
            ext = {1'b0, x} + {1'b0, y};
            r   = ext[63:0] & m;
            c   = ext[eb * 8];
            sr  = |(r & sb);
            z   = (r == '0);
            ov  = (sx == sy) && (sr != sx);
        end else begin
            ext = {1'b0, (x - y) & m};
            sr  = |(ext[63:0] & sb);
            eq  = (x == y);
            c   = (x < y);
            sgn = o inside {OP_SUB, OP_MIN, OP_MAX, OP_SLT, OP_SGT, OP_REDMAX};
            ov  = sgn ? ((sx != sy) && (sr != sx)) : c;
            lt  = sgn ? ((x ^ sb) < (y ^ sb)) : c;
            z   = eq;
            case (o)
                OP_SUB:                    r = ext[63:0];
                OP_MIN, OP_MINU:           r = lt ? x : y;
                OP_MAX, OP_MAXU, OP_REDMAX: r = lt ? y : x;
                OP_SEQ:                    r = 64'(eq);
                OP_SNE:                    r = 64'(!eq);
                OP_SLT, OP_SLTU:           r = 64'(lt);
                default:                   r = 64'(!(eq || lt));
            endcase
        end
    endtask

    task automatic compute_expected(input vadd_op_e o, input osize_e s,
                                    input vdata_t a, input vdata_t b);
        logic [63:0] v [8];
        logic [63:0] r;
        logic        z;
        logic        c;
        logic        ov;
        int          eb;
        int          n;
        int          top;
        int          cnt;
        eb = 1 << s;
        n  = 8 / eb;
        exp_result = '0;
        exp_zf     = '0;
        exp_cf     = '0;
        exp_of     = '0;
        exp_lat    = 3'd1;
        if (o inside {OP_REDSUM, OP_REDMAX}) begin
            for (int e = 0; e < n; e++) begin
                v[e] = (a >> (e * eb * 8)) & elem_mask(eb);
            end
            // Seed pass, then halving folds
            pair_eval(o, v[0], b & elem_mask(eb), eb, v[0], z, c, ov);
            cnt = n;
            while (cnt > 1) begin
                cnt = cnt / 2;
                for (int i = cnt - 1; i >= 0; i--) begin
                    pair_eval(o, v[i], v[i + cnt], eb, v[i], z, c, ov);
                end
            end
            exp_result     = v[0];
            exp_zf[eb - 1] = z;
            exp_cf[eb - 1] = c;
            exp_of[eb - 1] = ov;
            exp_lat        = 3'(4 - s);
        end else begin
            for (int e = 0; e < n; e++) begin
                top = e * eb + eb - 1;
                pair_eval(o, (a >> (e * eb * 8)) & elem_mask(eb),
                          (b >> (e * eb * 8)) & elem_mask(eb), eb, r, z, c, ov);
                if (o inside {OP_SEQ, OP_SNE, OP_SLT, OP_SLTU, OP_SGT, OP_SGTU}) begin
                    exp_result[e] = r[0];
                end else begin
                    exp_result  = exp_result | (r << (e * eb * 8));
                    exp_zf[top] = z;
                    exp_cf[top] = c;
                    exp_of[top] = ov;
                end
            end
        end
    endtask

    task automatic drive_junk_start();
        start = 1'b1;
        op    = OP_ADD;
        osize = OS_64;
        srca  = rand_bits(64);
        srcb  = rand_bits(64);
    endtask

    // Entered and left on a falling edge
    task automatic run_test(input vadd_op_e o, input osize_e s, input vdata_t a,
                            input vdata_t b, input logic poke);
        int   cycles;
        int   errs_before;
        logic timed_out;
        compute_expected(o, s, a, b);
        errs_before = dut.chk.err_cnt;
        op    = o;
        osize = s;
        srca  = a;
        srcb  = b;
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        // Longest op needs 4 cycles
        while (!done && cycles < 16) begin
            if (poke && cycles == 0) begin
                drive_junk_start();
            end
            @(negedge clk);
            start  = 1'b0;
            cycles = cycles + 1;
        end
        timed_out = !done;
        if (poke && done) begin
            drive_junk_start();
        end
        @(negedge clk);
        start    = 1'b0;
        test_cnt = test_cnt + 1;
        if (timed_out) begin
            fail_cnt = fail_cnt + 1;
            $display("test %0d %s size %0d: done never came", test_cnt, o.name(), 8 << s);
        end else if (dut.chk.err_cnt != errs_before) begin
            fail_cnt = fail_cnt + 1;
            $display("test %0d %s size %0d: mismatch", test_cnt, o.name(), 8 << s);
        end else begin
            $display("test %0d %s size %0d: ok", test_cnt, o.name(), 8 << s);
        end
    endtask

    initial begin
        vadd_op_e o;
        osize_e   s;
        vdata_t   a;
        clk      = 1'b0;
        rst_n    = 1'b1;
        start    = 1'b0;
        op       = OP_ADD;
        osize    = OS_8;
        srca     = '0;
        srcb     = '0;
        lfsr     = 32'hce00_6a26;
        test_cnt = 0;
        fail_cnt = 0;
        #1 rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        for (int sz = 0; sz < NUM_OSIZES; sz++) begin
            s = osize_e'(sz);
            for (int k = 0; k <= 13; k++) begin
                o = vadd_op_e'(k);
                a = rand_bits(64);
                if (o inside {OP_ADD, OP_SUB, OP_REDSUM, OP_REDMAX}) begin
                    run_test(o, s, a, rand_bits(64), 1'b0);
                end else begin
                    run_test(o, s, a, mix_equal(a, s), 1'b0);
                end
            end
            // Zero flag cases
            a = rand_bits(64);
            run_test(OP_ADD, s, a, zero_partner(a, s, 1'b1), 1'b0);
            a = rand_bits(64);
            run_test(OP_SUB, s, a, zero_partner(a, s, 1'b0), 1'b0);
        end

        // Start pulses while busy must be ignored
        run_test(OP_REDSUM, OS_8, rand_bits(64), rand_bits(64), 1'b1);
        run_test(OP_REDMAX, OS_16, rand_bits(64), rand_bits(64), 1'b1);
        run_test(OP_SLT, OS_32, rand_bits(64), rand_bits(64), 1'b1);

        $display("tests %0d failed %0d checker errors %0d", test_cnt, fail_cnt,
                 dut.chk.err_cnt);
        if (fail_cnt == 0 && dut.chk.err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
design/vadd_pkg.sv
design/vadd_ctrl.sv
design/vadd_seg_adder.sv
design/vadd_select.sv
design/vadd_reduct_src.sv
design/vadd_result_reg.sv
design/vadd_unit.sv
sim/vadd_checker.sv
sim/vadd_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the vadd_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal --top-module vadd_tb -f files.f -o vadd_sim
./obj_dir/vadd_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
exit 1
